// File: files.f
source/flash_boot_pkg.sv
source/flash_reader.sv
source/byte_fifo.sv
source/boot_interpreter.sv
source/boot_ram.sv
source/boot_memories.sv
source/flash_boot_top.sv
verif/flash_model.sv
verif/tb_flash_boot.sv

// File: source/boot_interpreter.sv
/* Boot language interpreter: runs of code/data words, rate, address and count loads, end */
`timescale 1ns/1ns
module boot_interpreter import flash_boot_pkg::*; (
  input  logic       clk,
  input  logic       arstn,
  input  logic       i_valid,               // FIFO has a byte
  input  logic [7:0] i_data,
  output logic       o_pop,
  output rate_t      o_rate,
  output logic       o_rate_load,
  output logic       o_stop,                // End command pulse
  output logic       o_wr_valid,
  output mem_wr_t    o_wr,
  output logic       o_p_reset,
  output logic       o_booting
);

  interp_state_e         state;
  boot_op_e              op;
  logic                  run_target;        // Target of the current run
  logic [1:0]            bytes;             // Bytes per word minus one
  logic [1:0]            byte_cnt;          // Bytes left in this word
  logic                  sel_count;         // Register load goes to count
  logic [15:0]           dest;              // Next write address
  logic [15:0]           count;             // Words left minus one
  logic [DATA_WIDTH-1:0] word;
  logic [DATA_WIDTH-1:0] word_next;
  logic                  first_byte;

  assign o_pop      = i_valid & (state != IS_DONE);   // One byte per cycle at most
  assign first_byte = (byte_cnt == bytes);
  assign word_next  = first_byte ? DATA_WIDTH'(i_data)
                                 : {word[DATA_WIDTH-9:0], i_data};  // Big-endian

  // ========================================
  // Command decode
  // ========================================
  always_comb begin
    if (!i_data[7])      op = OP_DATA_RUN;
    else if (!i_data[6]) op = OP_SET_RATE;
    else if (i_data[5])  op = OP_END;
    else                 op = OP_SET_REG;
  end

  // ========================================
  // Interpreter FSM
  // ========================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state       <= IS_CMD;
      run_target  <= 1'b0;
      bytes       <= 2'd0;
      byte_cnt    <= 2'd0;
      sel_count   <= 1'b0;
      dest        <= 16'd0;
      count       <= 16'd0;
      o_wr_valid  <= 1'b0;
      o_rate_load <= 1'b0;
      o_stop      <= 1'b0;
      o_p_reset   <= 1'b1;                    // Processor held until end
      o_booting   <= 1'b1;
    end else begin
      o_wr_valid  <= 1'b0;
      o_rate_load <= 1'b0;
      o_stop      <= 1'b0;
      if (o_pop) begin
        case (state)
          IS_CMD:
            case (op)
              OP_DATA_RUN: begin
                run_target <= i_data[2];
                bytes      <= i_data[1:0];
                byte_cnt   <= i_data[1:0];
                state      <= IS_RUN;
              end
              OP_SET_RATE: o_rate_load <= 1'b1;
              OP_SET_REG:
                if (i_data[4:2] == 3'b000) begin   // Other 110x codes ignored
                  sel_count <= i_data[1];
                  state     <= i_data[0] ? IS_REG_HI : IS_REG_LO;
                end
              default: begin                        // OP_END
                o_stop    <= 1'b1;
                o_p_reset <= i_data[4];
                o_booting <= 1'b0;
                state     <= IS_DONE;
              end
            endcase
          IS_RUN:
            if (byte_cnt != 2'd0) begin
              byte_cnt <= byte_cnt - 2'd1;
            end else begin
              byte_cnt   <= bytes;              // Word complete
              o_wr_valid <= 1'b1;
              dest       <= dest + 16'd1;
              if (count != 16'd0) count <= count - 16'd1;
              else state <= IS_CMD;              // Last word, count stays 0
            end
          IS_REG_HI: begin
            if (sel_count) count[15:8] <= i_data;
            else dest[15:8] <= i_data;
            state <= IS_REG_LO;
          end
          IS_REG_LO: begin
            if (sel_count) count[7:0] <= i_data;
            else dest[7:0] <= i_data;            // High byte kept
            state <= IS_CMD;
          end
          default: ;                             // IS_DONE
        endcase
      end
    end
  end

  // Word assembly and write payload
  always_ff @(posedge clk) begin
    if (o_pop && state == IS_RUN) begin
      word        <= word_next;
      o_wr.target <= run_target;
      o_wr.addr   <= dest;
      o_wr.data   <= word_next;
    end
    if (o_pop && state == IS_CMD && op == OP_SET_RATE) o_rate <= i_data[3:0];
  end

endmodule

// File: source/boot_memories.sv
/* Code and data RAMs shared by the boot loader and the processor */
`timescale 1ns/1ns
module boot_memories import flash_boot_pkg::*; #(
  parameter int CODE_SIZE = 10,                   // log2 of code words
  parameter int DATA_SIZE = 10                    // log2 of data words
) (
  input  logic                  clk,
  input  logic                  arstn,
  input  logic                  i_wr_valid,       // Loader write this cycle
  input  mem_wr_t               i_wr,
  input  logic [CODE_SIZE-1:0]  i_code_addr,
  input  logic                  i_mem_rd,
  input  logic                  i_mem_wr,
  input  logic [DATA_SIZE-1:0]  i_mem_addr,
  input  logic [DATA_WIDTH-1:0] i_mem_din,
  output logic [CODE_WIDTH-1:0] o_insn,
  output logic [DATA_WIDTH-1:0] o_mem_dout,
  output logic                  o_p_hold
);

  logic                  code_we;
  logic                  data_we;
  logic [CODE_SIZE-1:0]  code_addr;
  logic [DATA_SIZE-1:0]  data_addr;
  logic [DATA_WIDTH-1:0] data_din;

  assign o_p_hold  = i_wr_valid;                  // Loader owns both RAMs
  assign code_we   = i_wr_valid & ~i_wr.target;
  assign data_we   = i_wr_valid & i_wr.target;
  assign code_addr = code_we ? i_wr.addr[CODE_SIZE-1:0] : i_code_addr;
  assign data_addr = data_we ? i_wr.addr[DATA_SIZE-1:0] : i_mem_addr;
  assign data_din  = data_we ? i_wr.data : i_mem_din;

  // ========================================
  // RAM instances
  // ========================================
  boot_ram #(
    .ADDR_BITS (CODE_SIZE),
    .WORD_BITS (CODE_WIDTH)
  ) u_code_ram (
    .clk    (clk),
    .i_addr (code_addr),
    .i_din  (i_wr.data[CODE_WIDTH-1:0]),         // Low bits of the word
    .i_we   (code_we),
    .i_re   (~o_p_hold),                         // Fetch holds during loads
    .o_dout (o_insn)
  );

  boot_ram #(
    .ADDR_BITS (DATA_SIZE),
    .WORD_BITS (DATA_WIDTH)
  ) u_data_ram (
    .clk    (clk),
    .i_addr (data_addr),
    .i_din  (data_din),
    .i_we   (data_we | (i_mem_wr & ~o_p_hold)),  // Processor write dropped on hold
    .i_re   (i_mem_rd & ~o_p_hold),
    .o_dout (o_mem_dout)
  );

  // Interpreter address must fit the RAM it targets
  a_addr_range: assert property (@(posedge clk) disable iff (!arstn)
    i_wr_valid |-> (i_wr.addr < (i_wr.target ? 2**DATA_SIZE : 2**CODE_SIZE)))
    else $error("loader address 0x%h out of range", i_wr.addr);

endmodule

// File: source/boot_ram.sv
/* Single-port RAM, synchronous write, registered read held while not enabled */
`timescale 1ns/1ns
module boot_ram #(
  parameter int ADDR_BITS = 10,
  parameter int WORD_BITS = 18
) (
  input  logic                 clk,
  input  logic [ADDR_BITS-1:0] i_addr,
  input  logic [WORD_BITS-1:0] i_din,
  input  logic                 i_we,
  input  logic                 i_re,
  output logic [WORD_BITS-1:0] o_dout
);

  logic [WORD_BITS-1:0] mem [2**ADDR_BITS];

  always_ff @(posedge clk) begin
    if (i_we) mem[i_addr] <= i_din;
    if (i_re) o_dout <= mem[i_addr];       // Old data on read during write
  end

endmodule

// File: source/byte_fifo.sv
/* Byte FIFO between flash reader and boot interpreter, with flush */
`timescale 1ns/1ns
module byte_fifo #(
  parameter int DEPTH = 8
) (
  input  logic                         clk,
  input  logic                         arstn,
  input  logic                         i_push,
  input  logic [7:0]                   i_push_data,
  input  logic                         i_pop,
  input  logic                         i_flush,  // Drops all entries
  output logic                         o_valid,
  output logic [7:0]                   o_data,
  output logic [$clog2(DEPTH+1)-1:0]   o_space
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [7:0]    mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          do_push;
  logic          do_pop;

  function automatic logic [AW-1:0] bump(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;  // Wrap for any depth
  endfunction

  assign full    = (count == CW'(DEPTH));
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];                   // Head visible the cycle after push
  assign o_space = CW'(DEPTH) - count;
  assign do_push = i_push & ~full;
  assign do_pop  = i_pop & o_valid;

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (i_flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= bump(wr_ptr);
      if (do_pop) rd_ptr <= bump(rd_ptr);
      count <= count + CW'(do_push) - CW'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= i_push_data;
  end

  // Reader must count its in-flight byte, interpreter must check valid
  a_no_overflow: assert property (@(posedge clk) disable iff (!arstn)
    i_push |-> !full)
    else $error("push into full FIFO");
  a_no_underflow: assert property (@(posedge clk) disable iff (!arstn)
    i_pop |-> o_valid)
    else $error("pop from empty FIFO");

endmodule

// File: source/flash_boot_pkg.sv
/* Shared constants, enums and structs of the flash boot loader:
   word widths, flash opcode and format, FSM states, boot opcodes, RAM write record */
package flash_boot_pkg;

  // ========================================
  // Widths and constants
  // ========================================
  localparam int DATA_WIDTH = 18;                 // Data RAM word
  localparam int CODE_WIDTH = 16;                 // Code RAM word

  localparam logic [7:0] FAST_READ_OP = 8'h0B;    // SPI fast read, needs one dummy byte

  typedef logic [3:0] rate_t;                     // Flash SCLK divisor
  localparam rate_t RATE_POR = 4'd7;              // Slow until the image speeds it up

  // ========================================
  // Enums
  // ========================================
  typedef enum logic [2:0] {
    FMT_IDLE = 3'd0,                              // CS# high
    FMT_READ = 3'd2                               // Byte exchange, CS# held low
  } flash_format_e;

  typedef enum logic [1:0] {
    RD_OPEN,                                      // Opcode and 4 header bytes
    RD_STREAM,                                    // Dummy exchanges, bytes to FIFO
    RD_DRAIN,                                     // Finish last exchange after stop
    RD_DONE
  } reader_state_e;

  typedef enum logic [1:0] {
    OP_DATA_RUN,                                  // 0xxx xtbb
    OP_SET_RATE,                                  // 10xx rrrr
    OP_SET_REG,                                   // 110x xxxx
    OP_END                                        // 111r xxxx
  } boot_op_e;

  typedef enum logic [2:0] {
    IS_CMD,
    IS_RUN,
    IS_REG_HI,
    IS_REG_LO,
    IS_DONE
  } interp_state_e;

  // One loader write into code or data RAM
  typedef struct packed {
    logic                  target;                // 0 code, 1 data
    logic [15:0]           addr;
    logic [DATA_WIDTH-1:0] data;
  } mem_wr_t;

endpackage

// File: source/flash_boot_top.sv
/* Flash boot loader top: reader, byte FIFO, interpreter and code/data RAMs */
`timescale 1ns/1ns
module flash_boot_top import flash_boot_pkg::*; #(
  parameter int CODE_SIZE  = 10,
  parameter int DATA_SIZE  = 10,
  parameter int BASEBLOCK  = 0,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  arstn,
  // Flash
  input  logic                  i_f_ready,
  input  logic [7:0]            i_f_din,
  output logic                  o_f_wr,
  output logic [7:0]            o_f_dout,
  output flash_format_e         o_f_format,
  output rate_t                 o_f_rate,
  // Processor
  input  logic [CODE_SIZE-1:0]  i_code_addr,
  input  logic                  i_mem_rd,
  input  logic                  i_mem_wr,
  input  logic [DATA_SIZE-1:0]  i_mem_addr,
  input  logic [DATA_WIDTH-1:0] i_mem_din,
  output logic [CODE_WIDTH-1:0] o_insn,
  output logic [DATA_WIDTH-1:0] o_mem_dout,
  output logic                  o_p_hold,
  output logic                  o_p_reset,
  output logic                  o_booting
);

  localparam int SW = $clog2(FIFO_DEPTH + 1);

  logic          push;
  logic [7:0]    push_data;
  logic [SW-1:0] space;
  logic          fifo_valid;
  logic [7:0]    fifo_data;
  logic          pop;
  rate_t         rate;
  logic          rate_load;
  logic          stop;
  logic          wr_valid;
  mem_wr_t       wr;

  flash_reader #(
    .BASEBLOCK  (BASEBLOCK),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_flash_reader (
    .clk         (clk),
    .arstn       (arstn),
    .i_f_ready   (i_f_ready),
    .i_f_din     (i_f_din),
    .i_space     (space),
    .i_rate      (rate),
    .i_rate_load (rate_load),
    .i_stop      (stop),
    .o_f_wr      (o_f_wr),
    .o_f_dout    (o_f_dout),
    .o_f_format  (o_f_format),
    .o_f_rate    (o_f_rate),
    .o_push      (push),
    .o_push_data (push_data)
  );

  byte_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_byte_fifo (
    .clk         (clk),
    .arstn       (arstn),
    .i_push      (push),
    .i_push_data (push_data),
    .i_pop       (pop),
    .i_flush     (stop),                  // Leftover bytes after end
    .o_valid     (fifo_valid),
    .o_data      (fifo_data),
    .o_space     (space)
  );

  boot_interpreter u_boot_interpreter (
    .clk         (clk),
    .arstn       (arstn),
    .i_valid     (fifo_valid),
    .i_data      (fifo_data),
    .o_pop       (pop),
    .o_rate      (rate),
    .o_rate_load (rate_load),
    .o_stop      (stop),
    .o_wr_valid  (wr_valid),
    .o_wr        (wr),
    .o_p_reset   (o_p_reset),
    .o_booting   (o_booting)
  );

  boot_memories #(
    .CODE_SIZE (CODE_SIZE),
    .DATA_SIZE (DATA_SIZE)
  ) u_boot_memories (
    .clk         (clk),
    .arstn       (arstn),
    .i_wr_valid  (wr_valid),
    .i_wr        (wr),
    .i_code_addr (i_code_addr),
    .i_mem_rd    (i_mem_rd),
    .i_mem_wr    (i_mem_wr),
    .i_mem_addr  (i_mem_addr),
    .i_mem_din   (i_mem_din),
    .o_insn      (o_insn),
    .o_mem_dout  (o_mem_dout),
    .o_p_hold    (o_p_hold)
  );

endmodule

// File: source/flash_reader.sv
/* Flash reader: fast-read header sequencer and byte streamer into the boot FIFO */
`timescale 1ns/1ns
module flash_reader import flash_boot_pkg::*; #(
  parameter int BASEBLOCK  = 0,                   // First 64KB sector of the image
  parameter int FIFO_DEPTH = 8
) (
  input  logic                               clk,
  input  logic                               arstn,
  input  logic                               i_f_ready,  // Flash idle, i_f_din valid
  input  logic [7:0]                         i_f_din,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0]    i_space,    // FIFO free entries
  input  rate_t                              i_rate,
  input  logic                               i_rate_load,
  input  logic                               i_stop,     // End command seen
  output logic                               o_f_wr,     // One-cycle exchange strobe
  output logic [7:0]                         o_f_dout,
  output flash_format_e                      o_f_format,
  output rate_t                              o_f_rate,
  output logic                               o_push,
  output logic [7:0]                         o_push_data
);

  localparam int SW = $clog2(FIFO_DEPTH + 1);

  reader_state_e state;
  logic [2:0]    hdr_cnt;                         // Header bytes sent
  logic          in_flight;                       // Exchange started, not finished
  logic          f_ok;
  logic          f_done;
  logic          can_issue;
  logic [7:0]    next_dout;

  assign f_ok      = i_f_ready & ~o_f_wr & ~in_flight;
  assign f_done    = i_f_ready & ~o_f_wr & in_flight;   // Received byte on i_f_din
  assign can_issue = f_ok & (i_space > SW'(o_push));    // Pending push takes a slot

  always_comb begin
    case (hdr_cnt)
      3'd0:    next_dout = FAST_READ_OP;
      3'd1:    next_dout = BASEBLOCK[7:0];
      default: next_dout = 8'h00;                 // Address low bytes, dummy, stream
    endcase
  end

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state      <= RD_OPEN;
      hdr_cnt    <= 3'd0;
      in_flight  <= 1'b0;
      o_f_wr     <= 1'b0;
      o_f_format <= FMT_IDLE;
      o_f_rate   <= RATE_POR;
      o_push     <= 1'b0;
    end else begin
      o_f_wr <= 1'b0;                             // Strobes are single cycle
      o_push <= 1'b0;
      if (f_done) in_flight <= 1'b0;
      if (i_stop && state != RD_DONE) begin
        state <= RD_DRAIN;                        // Any byte in flight is dropped
      end else begin
        case (state)
          RD_OPEN:
            if (f_ok) begin
              if (hdr_cnt == 3'd5) begin
                state <= RD_STREAM;               // Fifth header byte done
              end else begin
                o_f_wr     <= 1'b1;
                in_flight  <= 1'b1;
                o_f_format <= FMT_READ;           // CS# low from the opcode on
                hdr_cnt    <= hdr_cnt + 3'd1;
              end
            end
          RD_STREAM: begin
            if (f_done) o_push <= 1'b1;
            if (can_issue) begin
              o_f_wr    <= 1'b1;
              in_flight <= 1'b1;
            end
          end
          RD_DRAIN:
            if (!in_flight || f_done) begin
              o_f_format <= FMT_IDLE;             // Raise CS#
              state      <= RD_DONE;
            end
          default: ;                              // RD_DONE, parked
        endcase
      end
      if (i_rate_load) o_f_rate <= i_rate;
    end
  end

  // Data path
  always_ff @(posedge clk) begin
    o_f_dout    <= (state == RD_OPEN) ? next_dout : 8'h00;
    o_push_data <= i_f_din;                       // Paired with o_push one cycle later
  end

  // Flash must still be ready when it samples the strobe
  a_wr_ready: assert property (@(posedge clk) disable iff (!arstn)
    o_f_wr |-> i_f_ready)
    else $error("o_f_wr while flash busy");

endmodule

// File: verif/flash_model.sv
/* SPI flash byte model: fast-read header check, boot image playback,
   random ready delays of 1 to 6 cycles */
`timescale 1ns/1ns
module flash_model import flash_boot_pkg::*; #(
  parameter int BASEBLOCK = 0,
  parameter int IMG_MAX   = 256,
  parameter int SEED      = 32'h15ef
) (
  input  logic          clk,
  input  logic          arstn,
  input  logic          i_f_wr,        // Exchange strobe from the controller
  input  logic [7:0]    i_f_dout,
  input  flash_format_e i_f_format,
  output logic          o_f_ready,
  output logic [7:0]    o_f_din,
  output logic          o_proto_err    // Sticky, header or chip select wrong
);

  logic [7:0] image [IMG_MAX];         // Bytes at the base sector, filled by the testbench
  int         seed = SEED;
  int         xchg;                    // Exchanges seen so far
  int         wait_cnt;                // Ready low cycles left
  logic       busy;
  logic [7:0] resp;                    // Byte returned at the end of the exchange

  // Opcode, sector, two address bytes, then the dummy byte
  function automatic logic [7:0] header_byte(input int n);
    case (n)
      0:       return FAST_READ_OP;
      1:       return 8'(BASEBLOCK);
      default: return 8'h00;
    endcase
  endfunction

  always @(negedge clk or negedge arstn) begin
    if (!arstn) begin
      o_f_ready   <= 1'b1;
      o_f_din     <= 8'h00;
      o_proto_err <= 1'b0;
      busy        <= 1'b0;
      xchg        <= 0;
      wait_cnt    <= 0;
      resp        <= 8'h00;
    end else if (i_f_wr) begin
      if (xchg < 5 && i_f_dout !== header_byte(xchg)) begin
        $display("flash header byte %0d is 0x%h, expected 0x%h",
                 xchg, i_f_dout, header_byte(xchg));
        o_proto_err <= 1'b1;
      end
      if (i_f_format != FMT_READ) begin
        $display("flash exchange %0d started with chip select high", xchg);
        o_proto_err <= 1'b1;
      end
      resp     <= (xchg >= 5 && xchg - 5 < IMG_MAX) ? image[xchg - 5] : 8'hFF;
      wait_cnt <= 1 + ($unsigned($random(seed)) % 6);
      busy     <= 1'b1;
      xchg     <= xchg + 1;
    end else if (busy) begin
      if (o_f_ready) begin
        o_f_ready <= 1'b0;             // Drop one cycle after the strobe
      end else if (wait_cnt > 1) begin
        wait_cnt <= wait_cnt - 1;
      end else begin
        o_f_din   <= resp;             // Held until the next exchange
        o_f_ready <= 1'b1;
        busy      <= 1'b0;
      end
    end
  end

endmodule

// File: verif/tb_flash_boot.sv
/* Flash boot loader testbench with random boot image, reference RAM model,
   flash protocol monitor, processor-port readback and processor write test */
`timescale 1ns/1ns
module tb_flash_boot import flash_boot_pkg::*; ();

  localparam int CODE_SIZE  = 10;
  localparam int DATA_SIZE  = 10;
  localparam int BASEBLOCK  = 0;
  localparam int FIFO_DEPTH = 8;
  localparam int IMG_MAX    = 256;

  logic                  clk = 1'b0;
  logic                  arstn;
  logic                  f_ready;
  logic [7:0]            f_din;
  logic                  f_wr;
  logic [7:0]            f_dout;
  flash_format_e         f_format;
  rate_t                 f_rate;
  logic [CODE_SIZE-1:0]  code_addr;
  logic                  mem_rd;
  logic                  mem_wr;
  logic [DATA_SIZE-1:0]  mem_addr;
  logic [DATA_WIDTH-1:0] mem_din;
  logic [CODE_WIDTH-1:0] insn;
  logic [DATA_WIDTH-1:0] mem_dout;
  logic                  p_hold;
  logic                  p_reset;
  logic                  booting;
  logic                  proto_err;

  int                    seed = 32'h15ef;
  int                    img_len;
  int                    cycles = 0;
  int                    limit = IMG_MAX * 10 + 200;   // Tightened once the image exists
  int                    hold_cycles = 0;              // Cycles with o_p_hold high
  int                    m_words;                      // Loader writes in the image
  logic [15:0]           m_dest;                       // Expected interpreter registers
  logic [15:0]           m_count;
  rate_t                 m_rate;
  logic                  m_end_r;
  logic [CODE_WIDTH-1:0] code_ref [2**CODE_SIZE];
  logic [DATA_WIDTH-1:0] data_ref [2**DATA_SIZE];
  bit                    code_wr [2**CODE_SIZE];
  bit                    data_wr [2**DATA_SIZE];

  always #5 clk = ~clk;

  flash_boot_top #(
    .CODE_SIZE  (CODE_SIZE),
    .DATA_SIZE  (DATA_SIZE),
    .BASEBLOCK  (BASEBLOCK),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_flash_boot_top (
    .clk         (clk),
    .arstn       (arstn),
    .i_f_ready   (f_ready),
    .i_f_din     (f_din),
    .o_f_wr      (f_wr),
    .o_f_dout    (f_dout),
    .o_f_format  (f_format),
    .o_f_rate    (f_rate),
    .i_code_addr (code_addr),
    .i_mem_rd    (mem_rd),
    .i_mem_wr    (mem_wr),
    .i_mem_addr  (mem_addr),
    .i_mem_din   (mem_din),
    .o_insn      (insn),
    .o_mem_dout  (mem_dout),
    .o_p_hold    (p_hold),
    .o_p_reset   (p_reset),
    .o_booting   (booting)
  );

  flash_model #(
    .BASEBLOCK (BASEBLOCK),
    .IMG_MAX   (IMG_MAX),
    .SEED      (32'h15ef)
  ) u_flash_model (
    .clk         (clk),
    .arstn       (arstn),
    .i_f_wr      (f_wr),
    .i_f_dout    (f_dout),
    .i_f_format  (f_format),
    .o_f_ready   (f_ready),
    .o_f_din     (f_din),
    .o_proto_err (proto_err)
  );

  // ========================================
  // Reporting
  // ========================================
  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // ========================================
  // Boot image and reference model
  // ========================================
  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  task automatic add_byte(input logic [7:0] b);
    u_flash_model.image[img_len] = b;
    img_len++;
  endtask

  task automatic add_rate();
    logic [31:0] r;
    r = rand_word();
    add_byte({2'b10, r[5:4], r[3:0]});               // xx bits are don't care
    m_rate = r[3:0];
  endtask

  task automatic add_reg_load(input bit to_count, input bit both, input logic [15:0] val);
    logic [15:0] cur;
    add_byte({6'b110000, to_count, both});
    if (both) add_byte(val[15:8]);
    add_byte(val[7:0]);
    cur = to_count ? m_count : m_dest;
    cur = both ? val : {cur[15:8], val[7:0]};        // Low-only keeps the high byte
    if (to_count) m_count = cur;
    else m_dest = cur;
  endtask

  // Run of count+1 words with nb bytes each, big-endian
  task automatic add_run(input bit target, input int nb);
    logic [31:0] r;
    logic [23:0] w;
    int          n;
    r = rand_word();
    add_byte({1'b0, r[3:0], target, 2'(nb - 1)});
    n = m_count + 1;
    for (int k = 0; k < n; k++) begin
      r = rand_word();
      w = '0;
      for (int j = 0; j < nb; j++) begin
        add_byte(r[8*j +: 8]);
        w = {w[15:0], r[8*j +: 8]};
      end
      if (target) begin
        data_ref[m_dest[DATA_SIZE-1:0]] = w[DATA_WIDTH-1:0];
        data_wr[m_dest[DATA_SIZE-1:0]]  = 1'b1;
      end else begin
        code_ref[m_dest[CODE_SIZE-1:0]] = w[CODE_WIDTH-1:0];   // Code keeps 16 bits
        code_wr[m_dest[CODE_SIZE-1:0]]  = 1'b1;
      end
      m_dest++;
      m_words++;
    end
    m_count = '0;
  endtask

  task automatic build_image();
    logic [31:0] r;
    for (int i = 0; i < IMG_MAX; i++) u_flash_model.image[i] = 8'(i) ^ 8'h5A;  // Filler
    img_len = 0;
    m_words = 0;
    m_dest  = '0;
    m_count = '0;
    m_rate  = RATE_POR;
    add_rate();
    r = rand_word();
    add_reg_load(1'b0, 1'b1, {8'h00, r[7:0]});       // Code base
    add_reg_load(1'b1, 1'b1, {14'd0, r[9:8]} + 16'd1);
    add_run(1'b0, 1);
    add_reg_load(1'b1, 1'b0, {r[23:16], 6'd0, r[11:10]});
    add_run(1'b0, 2);
    add_byte(8'hCC);                                 // Unused 11xx code is ignored
    r = rand_word();
    add_reg_load(1'b0, 1'b1, {8'h01, r[7:0]});       // Data base
    add_reg_load(1'b1, 1'b0, {r[23:16], 6'd0, r[9:8]});
    add_run(1'b1, 3);
    add_reg_load(1'b0, 1'b0, r[31:16]);              // Random high byte must be ignored
    add_run(1'b1, 3);                                // Count left at 0 gives one word
    add_rate();
    r = rand_word();
    add_reg_load(1'b1, 1'b1, {14'd0, r[1:0]});
    add_run(1'b1, 1);
    add_reg_load(1'b1, 1'b0, {r[15:8], 6'd0, r[3:2]});
    add_run(1'b1, 2);
    add_reg_load(1'b0, 1'b1, {8'h02, r[23:16]});
    add_reg_load(1'b1, 1'b0, {8'h00, 6'd0, r[5:4]});
    add_run(1'b0, 3);                                // Truncated to 16 bits
    r = rand_word();
    m_end_r = r[4];
    add_byte({3'b111, r[4], r[3:0]});
  endtask

  // Every written address through the processor ports
  task automatic read_back();
    for (int a = 0; a < 2**DATA_SIZE; a++) begin
      if (code_wr[a] || data_wr[a]) begin
        code_addr = a[CODE_SIZE-1:0];
        mem_addr  = a[DATA_SIZE-1:0];
        mem_rd    = 1'b1;
        @(negedge clk);                              // One cycle read latency
        if (code_wr[a]) compare($sformatf("o_insn[%0h]", a), insn, code_ref[a]);
        if (data_wr[a]) compare($sformatf("o_mem_dout[%0h]", a), mem_dout, data_ref[a]);
      end
    end
    mem_rd = 1'b0;
  endtask

  // One processor data write, then its read
  task automatic write_read_data();
    logic [31:0]           r;
    logic [DATA_WIDTH-1:0] val;
    r         = rand_word();
    val       = r[DATA_WIDTH-1:0];
    r         = rand_word();
    mem_addr  = r[DATA_SIZE-1:0];
    mem_din   = val;
    mem_wr    = 1'b1;
    @(negedge clk);
    mem_wr    = 1'b0;
    mem_rd    = 1'b1;
    @(negedge clk);
    compare($sformatf("o_mem_dout[%0h]", mem_addr), mem_dout, val);
    mem_rd    = 1'b0;
  endtask

  // ========================================
  // Monitors and timeout
  // ========================================
  always @(negedge clk) begin
    if (arstn) begin
      if (p_hold) hold_cycles++;
      if (f_wr && !f_ready) begin
        $display("flash strobe issued while the flash was busy");
        abort_run();
      end
      if (!booting && f_format == FMT_IDLE && f_wr) begin
        $display("flash strobe issued after the end of boot");
        abort_run();
      end
      compare("flash protocol error flag", proto_err, 1'b0);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout, boot not finished within %0d cycles", limit);
      abort_run();
    end
  end

  initial begin
    arstn     = 1'b0;
    code_addr = '0;
    mem_rd    = 1'b0;
    mem_wr    = 1'b0;
    mem_addr  = '0;
    mem_din   = '0;
    build_image();
    limit = img_len * 10 + 200;
    repeat (10) @(negedge clk);
    compare("o_f_wr", f_wr, 1'b0);                   // Reset values
    compare("o_f_format", f_format, FMT_IDLE);
    compare("o_f_rate", f_rate, RATE_POR);
    compare("o_p_hold", p_hold, 1'b0);
    compare("o_p_reset", p_reset, 1'b1);
    compare("o_booting", booting, 1'b1);
    arstn = 1'b1;
    for (int i = 0; i < 2 && !f_wr; i++) @(negedge clk);
    compare("o_f_wr", f_wr, 1'b1);                   // First strobe right after reset
    while (booting) @(negedge clk);
    compare("o_p_reset", p_reset, m_end_r);
    compare("o_f_rate", f_rate, m_rate);             // Last rate command wins
    while (f_format != FMT_IDLE) @(negedge clk);     // Reader drains its last exchange
    read_back();
    write_read_data();
    repeat (4) @(negedge clk);
    compare("o_f_format", f_format, FMT_IDLE);
    compare("o_booting", booting, 1'b0);
    compare("o_p_hold cycles", hold_cycles, m_words);  // One hold per loader write
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
